// ==== src/predecode_cfg.svh ====
// Branch predecode configuration
`ifndef PREDECODE_CFG_SVH
`define PREDECODE_CFG_SVH

// instruction address width in bits.
`define PD_IP_WIDTH 48

// fetched instruction word width in bits.
`define PD_INSTR_WIDTH 64

// return stack entries, power of two.
`define PD_RAS_DEPTH 8

`endif

// ==== src/predecodePkg.sv ====
// Branch predecode types
`include "predecode_cfg.svh"

package predecodePkg;

  // length code from the fetch stage, 2'b11 is illegal.
  typedef enum logic [1:0] {
    len2 = 2'd0,
    len4 = 2'd1,
    len6 = 2'd2
  } lenCode_e;

  // result kind of one predecoded instruction.
  typedef enum logic [2:0] {
    none   = 3'd0,
    cond   = 3'd1,
    uncond = 3'd2,
    call   = 3'd3,
    ret    = 3'd4,
    indir  = 3'd5
  } jumpKind_e;

  // one word, two decodings picked by the length code.
  typedef union packed {
    struct packed {
      logic [`PD_INSTR_WIDTH-17:0] pad;
      logic [7:0]                  disp;
      logic [3:0]                  opHi;
      logic [3:0]                  cond;
    } compact;
    struct packed {
      logic [`PD_INSTR_WIDTH-13:0] disp;
      logic [3:0]                  cond;
      logic [7:0]                  opcode;
    } std;
  } instrWord_u;

endpackage

// ==== src/fetchAligner.sv ====
// Fetch input stage
`timescale 1ns/1ps
`include "predecode_cfg.svh"

module fetchAligner import predecodePkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    flush,
  input  logic                    inValid,
  input  instrWord_u              inInstr,
  input  lenCode_e                inLen,
  input  logic [`PD_IP_WIDTH-1:0] inIp,
  output logic                    s1Valid,
  output instrWord_u              s1Instr,
  output lenCode_e                s1Len,
  output logic [`PD_IP_WIDTH-1:0] s1Ip,
  output logic [`PD_IP_WIDTH-1:0] s1NextIp
);

  logic [3:0] lenBytes;

  // size in bytes, illegal code counts as 2.
  always_comb begin
    case (inLen)
      len4:    lenBytes = 4'd4;
      len6:    lenBytes = 4'd6;
      default: lenBytes = 4'd2;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
    end else if (flush) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;
    end
  end

  // payload only loads with a valid word.
  always_ff @(posedge clk) begin
    if (inValid) begin
      s1Instr  <= inInstr;
      s1Len    <= inLen;
      s1Ip     <= inIp;
      s1NextIp <= inIp + {{(`PD_IP_WIDTH-4){1'b0}}, lenBytes};
    end
  end

endmodule

// ==== src/jumpDecoder.sv ====
// Jump classification stage
`timescale 1ns/1ps
`include "predecode_cfg.svh"

module jumpDecoder import predecodePkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    flush,
  input  logic                    s1Valid,
  input  instrWord_u              s1Instr,
  input  lenCode_e                s1Len,
  input  logic [`PD_IP_WIDTH-1:0] s1Ip,
  input  logic [`PD_IP_WIDTH-1:0] s1NextIp,
  output logic                    s2Valid,
  output jumpKind_e               s2Kind,
  output logic [3:0]              s2Cond,
  output logic [`PD_IP_WIDTH-1:0] s2Disp,
  output logic [`PD_IP_WIDTH-1:0] s2Ip,
  output logic [`PD_IP_WIDTH-1:0] s2NextIp,
  output logic                    s2Illegal
);

  localparam logic [7:0] OpCondJump   = 8'hB0;
  localparam logic [7:0] OpUncondJump = 8'hB1;
  localparam logic [7:0] OpCall       = 8'hB2;
  localparam logic [7:0] OpReturn     = 8'hB3;
  localparam logic [7:0] OpIndirJump  = 8'hB4;
  localparam logic [3:0] CompactOpHi  = 4'hC;
  localparam logic [3:0] CondAlways   = 4'hF;

  jumpKind_e               kindNext;
  logic [3:0]              condNext;
  logic [`PD_IP_WIDTH-1:0] dispNext;
  logic                    illegalNext;
  logic [`PD_IP_WIDTH-1:0] compactDisp;
  logic [`PD_IP_WIDTH-1:0] std20Disp;
  logic [`PD_IP_WIDTH-1:0] std36Disp;
  logic [`PD_IP_WIDTH-1:0] stdDisp;

  // halfword counts, sign-extended and turned into bytes.
  assign compactDisp = {{(`PD_IP_WIDTH-9){s1Instr.compact.disp[7]}},
                        s1Instr.compact.disp, 1'b0};
  assign std20Disp   = {{(`PD_IP_WIDTH-21){s1Instr.std.disp[19]}},
                        s1Instr.std.disp[19:0], 1'b0};
  assign std36Disp   = {{(`PD_IP_WIDTH-37){s1Instr.std.disp[35]}},
                        s1Instr.std.disp[35:0], 1'b0};
  assign stdDisp     = (s1Len == len6) ? std36Disp : std20Disp;

  always_comb begin
    kindNext    = none;
    condNext    = 4'h0;
    dispNext    = '0;
    illegalNext = 1'b0;
    case (s1Len)
      len2: begin
        // compact form, condition sits in the opcode byte.
        if (s1Instr.compact.opHi == CompactOpHi) begin
          kindNext = (s1Instr.compact.cond == CondAlways) ? uncond : cond;
          condNext = s1Instr.compact.cond;
          dispNext = compactDisp;
        end
      end
      len4, len6: begin
        case (s1Instr.std.opcode)
          OpCondJump: begin
            kindNext = cond;
            dispNext = stdDisp;
          end
          OpUncondJump: begin
            kindNext = uncond;
            dispNext = stdDisp;
          end
          OpCall: begin
            kindNext = call;
            dispNext = stdDisp;
          end
          OpReturn:    kindNext = ret;
          OpIndirJump: kindNext = indir;
          default:     kindNext = none;
        endcase
        if (kindNext != none) begin
          condNext = s1Instr.std.cond;
        end
      end
      default: begin
        // fourth length encoding.
        illegalNext = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s2Valid <= 1'b0;
    end else if (flush) begin
      s2Valid <= 1'b0;
    end else begin
      s2Valid <= s1Valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1Valid) begin
      s2Kind    <= kindNext;
      s2Cond    <= condNext;
      s2Disp    <= dispNext;
      s2Ip      <= s1Ip;
      s2NextIp  <= s1NextIp;
      s2Illegal <= illegalNext;
    end
  end

endmodule

// ==== src/returnStack.sv ====
// Return address stack
`timescale 1ns/1ps
`include "predecode_cfg.svh"

module returnStack (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    push,
  input  logic                    pop,
  input  logic [`PD_IP_WIDTH-1:0] pushAddr,
  output logic [`PD_IP_WIDTH-1:0] rasTop,
  output logic                    rasEmpty
);

  localparam int PtrW = $clog2(`PD_RAS_DEPTH);
  localparam logic [PtrW:0] CountMax = `PD_RAS_DEPTH;

  logic [`PD_IP_WIDTH-1:0] entries [`PD_RAS_DEPTH];
  logic [PtrW-1:0]         wrPtr;
  logic [PtrW-1:0]         topPtr;
  logic [PtrW:0]           count;

  // top is the slot just below the write pointer.
  assign topPtr   = wrPtr - 1'b1;
  assign rasTop   = entries[topPtr];
  assign rasEmpty = (count == '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      count <= '0;
    end else if (push) begin
      // when full the write lands on the oldest entry.
      wrPtr <= wrPtr + 1'b1;
      if (count != CountMax) begin
        count <= count + 1'b1;
      end
    end else if (pop && !rasEmpty) begin
      wrPtr <= topPtr;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wrPtr] <= pushAddr;
    end
  end

endmodule

// ==== src/targetResolver.sv ====
// Target resolution stage
`timescale 1ns/1ps
`include "predecode_cfg.svh"

module targetResolver import predecodePkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    flush,
  input  logic                    s2Valid,
  input  jumpKind_e               s2Kind,
  input  logic [3:0]              s2Cond,
  input  logic [`PD_IP_WIDTH-1:0] s2Disp,
  input  logic [`PD_IP_WIDTH-1:0] s2Ip,
  input  logic [`PD_IP_WIDTH-1:0] s2NextIp,
  input  logic                    s2Illegal,
  input  logic [`PD_IP_WIDTH-1:0] rasTop,
  input  logic                    rasEmpty,
  output logic                    resValid,
  output jumpKind_e               resKind,
  output logic [3:0]              resCond,
  output logic [`PD_IP_WIDTH-1:0] resTarget,
  output logic                    resTargetKnown,
  output logic [`PD_IP_WIDTH-1:0] resFallThrough,
  output logic                    resIllegal
);

  logic [`PD_IP_WIDTH-1:0] targetNext;
  logic                    knownNext;

  always_comb begin
    case (s2Kind)
      cond, uncond, call: begin
        targetNext = s2Ip + s2Disp;
        knownNext  = 1'b1;
      end
      ret: begin
        // stack top as seen before this edge's push or pop.
        targetNext = rasTop;
        knownNext  = !rasEmpty;
      end
      default: begin
        targetNext = '0;
        knownNext  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid       <= 1'b0;
      resKind        <= none;
      resTargetKnown <= 1'b0;
    end else begin
      resValid <= s2Valid && !flush;
      if (s2Valid) begin
        resKind        <= s2Kind;
        resTargetKnown <= knownNext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2Valid) begin
      resCond        <= s2Cond;
      resTarget      <= targetNext;
      resFallThrough <= s2NextIp;
      resIllegal     <= s2Illegal;
    end
  end

endmodule

// ==== src/predecodeTop.sv ====
// Branch predecode top level
`timescale 1ns/1ps
`include "predecode_cfg.svh"

module predecodeTop import predecodePkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    flush,
  input  logic                    inValid,
  input  instrWord_u              inInstr,
  input  lenCode_e                inLen,
  input  logic [`PD_IP_WIDTH-1:0] inIp,
  output logic                    resValid,
  output jumpKind_e               resKind,
  output logic [3:0]              resCond,
  output logic [`PD_IP_WIDTH-1:0] resTarget,
  output logic                    resTargetKnown,
  output logic [`PD_IP_WIDTH-1:0] resFallThrough,
  output logic                    resIllegal
);

  logic                    s1Valid;
  instrWord_u              s1Instr;
  lenCode_e                s1Len;
  logic [`PD_IP_WIDTH-1:0] s1Ip;
  logic [`PD_IP_WIDTH-1:0] s1NextIp;
  logic                    s2Valid;
  jumpKind_e               s2Kind;
  logic [3:0]              s2Cond;
  logic [`PD_IP_WIDTH-1:0] s2Disp;
  logic [`PD_IP_WIDTH-1:0] s2Ip;
  logic [`PD_IP_WIDTH-1:0] s2NextIp;
  logic                    s2Illegal;
  logic [`PD_IP_WIDTH-1:0] rasTop;
  logic                    rasEmpty;
  logic                    rasPush;
  logic                    rasPop;

  // a flushed instruction leaves the stack alone.
  assign rasPush = s2Valid && !flush && (s2Kind == call);
  assign rasPop  = s2Valid && !flush && (s2Kind == ret);

  fetchAligner uFetch (
    .clk(clk), .arstN(arstN), .flush(flush), .inValid(inValid), .inInstr(inInstr),
    .inLen(inLen), .inIp(inIp), .s1Valid(s1Valid), .s1Instr(s1Instr), .s1Len(s1Len),
    .s1Ip(s1Ip), .s1NextIp(s1NextIp)
  );

  jumpDecoder uDecode (
    .clk(clk), .arstN(arstN), .flush(flush), .s1Valid(s1Valid), .s1Instr(s1Instr),
    .s1Len(s1Len), .s1Ip(s1Ip), .s1NextIp(s1NextIp), .s2Valid(s2Valid), .s2Kind(s2Kind),
    .s2Cond(s2Cond), .s2Disp(s2Disp), .s2Ip(s2Ip), .s2NextIp(s2NextIp),
    .s2Illegal(s2Illegal)
  );

  returnStack uRas (
    .clk(clk), .arstN(arstN), .push(rasPush), .pop(rasPop), .pushAddr(s2NextIp),
    .rasTop(rasTop), .rasEmpty(rasEmpty)
  );

  targetResolver uResolve (
    .clk(clk), .arstN(arstN), .flush(flush), .s2Valid(s2Valid), .s2Kind(s2Kind),
    .s2Cond(s2Cond), .s2Disp(s2Disp), .s2Ip(s2Ip), .s2NextIp(s2NextIp),
    .s2Illegal(s2Illegal), .rasTop(rasTop), .rasEmpty(rasEmpty), .resValid(resValid),
    .resKind(resKind), .resCond(resCond), .resTarget(resTarget),
    .resTargetKnown(resTargetKnown), .resFallThrough(resFallThrough),
    .resIllegal(resIllegal)
  );

endmodule

// ==== testbench/predecode_checker.sv ====
// Predecode protocol checker
`timescale 1ns/1ps

module predecode_checker import predecodePkg::*; (
  input logic      clk,
  input logic      arstN,
  input logic      flush,
  input logic      inValid,
  input logic      resValid,
  input jumpKind_e resKind,
  input logic      resTargetKnown
);

  // nothing leaves the pipe during reset.
  assert property (@(posedge clk) !arstN |-> !resValid)
    else $error("result valid during reset");

  assert property (@(posedge clk) disable iff (!arstN)
    (resValid && (resKind == indir || resKind == none)) |-> !resTargetKnown)
    else $error("target known for indirect or non-jump");

  // three stages with no flush in between.
  assert property (@(posedge clk) disable iff (!arstN)
    ($past(inValid, 3) && !$past(flush, 3) && !$past(flush, 2) && !$past(flush, 1))
      |-> resValid)
    else $error("result missing three cycles after input");

endmodule

bind predecodeTop predecode_checker uChecker (
  .clk(clk), .arstN(arstN), .flush(flush), .inValid(inValid), .resValid(resValid),
  .resKind(resKind), .resTargetKnown(resTargetKnown)
);

// ==== testbench/predecodeTb.sv ====
// Branch predecode testbench
`timescale 1ns/1ps
`include "predecode_cfg.svh"

module predecodeTb import predecodePkg::*; ();

  localparam int W = `PD_IP_WIDTH;
  localparam int ResultTimeout = 20;

  typedef struct packed {
    logic [31:0]  line;
    logic [31:0]  issueCycle;
    jumpKind_e    kind;
    logic [3:0]   cond;
    logic [W-1:0] target;
    logic         known;
    logic [W-1:0] fallThrough;
    logic         illegal;
  } expEntry_t;

  logic                    clk;
  logic                    arstN;
  logic                    flush;
  logic                    inValid;
  instrWord_u              inInstr;
  lenCode_e                inLen;
  logic [W-1:0]            inIp;
  logic                    resValid;
  jumpKind_e               resKind;
  logic [3:0]              resCond;
  logic [W-1:0]            resTarget;
  logic                    resTargetKnown;
  logic [W-1:0]            resFallThrough;
  logic                    resIllegal;

  expEntry_t   expQ[$];
  expEntry_t   curExp;
  expEntry_t   newExp;
  int          errCount;
  int          testCount;
  int          lineErrs;
  int          cycleCount;
  int          fd;
  int          lineNo;
  int          fieldCount;
  int          gapCycles;
  int          waitCycles;
  string       lineBuf;
  logic [63:0] opVal;
  logic [63:0] instrVal;
  logic [63:0] lenVal;
  logic [63:0] ipVal;
  logic [63:0] expVal;
  logic [63:0] kindVal;
  logic [63:0] condVal;
  logic [63:0] targetVal;
  logic [63:0] knownVal;
  logic [63:0] ftVal;
  logic [63:0] illVal;

  predecodeTop DUT (
    .clk(clk), .arstN(arstN), .flush(flush), .inValid(inValid), .inInstr(inInstr),
    .inLen(inLen), .inIp(inIp), .resValid(resValid), .resKind(resKind),
    .resCond(resCond), .resTarget(resTarget), .resTargetKnown(resTargetKnown),
    .resFallThrough(resFallThrough), .resIllegal(resIllegal)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // overall limit on run time.
  initial begin
    #(20 * 5000);
    $display("simulation ran past its time limit");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic checkKind(input int line, input jumpKind_e got, input jumpKind_e exp);
    if (got !== exp) begin
      $display("[ERROR] line %0d resKind got %h exp %h", line, got, exp);
      errCount++;
    end
  endtask

  task automatic checkCond(input int line, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("[ERROR] line %0d resCond got %h exp %h", line, got, exp);
      errCount++;
    end
  endtask

  task automatic checkAddr(input int line, input string name, input logic [W-1:0] got,
                           input logic [W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] line %0d %s got %h exp %h", line, name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkFlag(input int line, input string name, input logic got,
                           input logic exp);
    if (got !== exp) begin
      $display("[ERROR] line %0d %s got %h exp %h", line, name, got, exp);
      errCount++;
    end
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #1;
    inValid = 1'b0;
    flush   = 1'b0;
  endtask

  task automatic driveInstr(input logic [63:0] word, input logic [1:0] len,
                            input logic [W-1:0] ip);
    @(posedge clk);
    #1;
    inValid = 1'b1;
    flush   = 1'b0;
    inInstr = word;
    inLen   = lenCode_e'(len);
    inIp    = ip;
  endtask

  task automatic driveFlush();
    @(posedge clk);
    #1;
    inValid = 1'b0;
    flush   = 1'b1;
  endtask

  // results are sampled mid-cycle, away from the drive edge.
  always @(negedge clk) begin
    cycleCount++;
    if (arstN && resValid) begin
      if (expQ.size() == 0) begin
        $display("result arrived with no instruction pending, kind %h ip fall-through %h",
                 resKind, resFallThrough);
        errCount++;
      end else begin
        curExp   = expQ.pop_front();
        lineErrs = errCount;
        checkKind(curExp.line, resKind, curExp.kind);
        checkCond(curExp.line, resCond, curExp.cond);
        checkFlag(curExp.line, "resTargetKnown", resTargetKnown, curExp.known);
        // a return on an empty stack leaves the target undefined.
        if (curExp.known || curExp.kind != ret) begin
          checkAddr(curExp.line, "resTarget", resTarget, curExp.target);
        end
        checkAddr(curExp.line, "resFallThrough", resFallThrough, curExp.fallThrough);
        checkFlag(curExp.line, "resIllegal", resIllegal, curExp.illegal);
        testCount++;
        if (errCount == lineErrs) begin
          $display("line %0d ok", curExp.line);
        end else begin
          $display("line %0d failed", curExp.line);
        end
      end
    end else if (expQ.size() != 0) begin
      if (cycleCount - int'(expQ[0].issueCycle) > ResultTimeout) begin
        $display("no result for line %0d within %0d cycles", expQ[0].line, ResultTimeout);
        void'(expQ.pop_front());
        errCount++;
        testCount++;
      end
    end
  end

  initial begin
    arstN      = 1'b0;
    flush      = 1'b0;
    inValid    = 1'b0;
    inInstr    = '0;
    inLen      = len2;
    inIp       = '0;
    errCount   = 0;
    testCount  = 0;
    cycleCount = 0;
    lineNo     = 0;
    void'($urandom(32'h9e73));
    repeat (3) @(posedge clk);
    #1;
    arstN = 1'b1;
    fd = $fopen("testbench/predecode_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      $display("TESTS FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        lineBuf = "";
        void'($fgets(lineBuf, fd));
        if (lineBuf.len() < 2 || lineBuf.substr(0, 0) == "#") begin
          continue;
        end
        fieldCount = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %h %h", opVal, instrVal,
                             lenVal, ipVal, expVal, kindVal, condVal, targetVal,
                             knownVal, ftVal, illVal);
        lineNo++;
        if (fieldCount != 11) begin
          $display("trace line %0d is malformed", lineNo);
          errCount++;
          continue;
        end
        // op 0 may be preceded by idle cycles, 1 and 2 follow directly.
        if (opVal == 64'd0) begin
          gapCycles = $urandom % 3;
          repeat (gapCycles) idleCycle();
        end
        if (opVal == 64'd2) begin
          driveFlush();
        end else begin
          driveInstr(instrVal, lenVal[1:0], ipVal[W-1:0]);
          if (expVal[0]) begin
            newExp.line        = lineNo;
            newExp.issueCycle  = cycleCount;
            newExp.kind        = jumpKind_e'(kindVal[2:0]);
            newExp.cond        = condVal[3:0];
            newExp.target      = targetVal[W-1:0];
            newExp.known       = knownVal[0];
            newExp.fallThrough = ftVal[W-1:0];
            newExp.illegal     = illVal[0];
            expQ.push_back(newExp);
          end
        end
      end
      $fclose(fd);
      idleCycle();
      waitCycles = 0;
      while (expQ.size() != 0 && waitCycles < ResultTimeout) begin
        @(posedge clk);
        waitCycles++;
      end
      if (expQ.size() != 0) begin
        $display("timed out with %0d results still missing", expQ.size());
        errCount++;
      end
      // quiet cycles to catch stray results.
      repeat (4) @(posedge clk);
      $display("tests %0d, errors %0d", testCount, errCount);
      if (errCount == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/predecode_trace.txt ====
# op instr len ip expect kind cond target known fallthrough illegal, all hex
# op 0 normal, 1 right behind previous line, 2 flush pulse
0 10C3 0 1000 1 1 3 1020 1 1002 0
0 F0C5 0 2000 1 1 5 1FE0 1 2002 0
0 1002B0 1 3000 1 1 2 3200 1 3004 0
0 12340000FFFFE7B0 1 4000 1 1 7 3FFC 1 4004 0
0 100001B0 2 5000 1 1 1 25000 1 5006 0
0 7A00FFFFFFF004B0 2 6000 1 1 4 5E00 1 6006 0
0 08CF 0 7000 1 2 F 7010 1 7002 0
0 400B1 1 8000 1 2 0 8080 1 8004 0
0 12345678 1 9000 1 0 0 0 0 9004 0
0 A5 0 9100 1 0 0 0 0 9102 0
0 3B5 2 9200 1 0 0 0 0 9206 0
0 1000B2 1 A000 1 3 0 A200 1 A004 0
0 800B2 2 A200 1 3 0 A300 1 A206 0
0 EB3 1 A300 1 4 E A206 1 A304 0
0 B3 1 A210 1 4 0 A004 1 A214 0
0 100B2 1 B000 1 3 0 B020 1 B004 0
1 B3 1 B020 1 4 0 B004 1 B024 0
0 B2 1 C000 1 3 0 C000 1 C004 0
0 B2 1 C100 1 3 0 C100 1 C104 0
0 B2 1 C200 1 3 0 C200 1 C204 0
0 B2 1 C300 1 3 0 C300 1 C304 0
0 B2 1 C400 1 3 0 C400 1 C404 0
0 B2 1 C500 1 3 0 C500 1 C504 0
0 B2 1 C600 1 3 0 C600 1 C604 0
0 B2 1 C700 1 3 0 C700 1 C704 0
0 B2 1 C800 1 3 0 C800 1 C804 0
0 B3 1 D000 1 4 0 C804 1 D004 0
0 B3 1 D010 1 4 0 C704 1 D014 0
0 B3 1 D020 1 4 0 C604 1 D024 0
0 B3 1 D030 1 4 0 C504 1 D034 0
0 B3 1 D040 1 4 0 C404 1 D044 0
0 B3 1 D050 1 4 0 C304 1 D054 0
0 B3 1 D060 1 4 0 C204 1 D064 0
0 B3 1 D070 1 4 0 C104 1 D074 0
0 B3 1 D080 1 4 0 0 0 D084 0
0 5B4 1 E000 1 5 5 0 0 E004 0
0 10C3 3 E100 1 0 0 0 0 E102 1
0 B2 1 F000 1 3 0 F000 1 F004 0
1 B2 1 F100 0 0 0 0 0 0 0
1 B3 1 F200 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0
0 B3 1 F300 1 4 0 F004 1 F304 0

// ==== project.f ====
+incdir+src
src/predecodePkg.sv
src/fetchAligner.sv
src/jumpDecoder.sv
src/returnStack.sv
src/targetResolver.sv
src/predecodeTop.sv
testbench/predecode_checker.sv
testbench/predecodeTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := predecodeTb
FILELIST   := project.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
